// ==== source/rx_link_params.svh ====
/* Link-wide sizing macros for the two-lane ADC receive path.
   Included by the package and by every module that sizes a port or a buffer. */
`ifndef RX_LINK_PARAMS_SVH
`define RX_LINK_PARAMS_SVH

// Number of serial lanes, the sample word is 8 bits per lane
`define NUM_LANES 2

// Core clock cycles per local multiframe
`define LMFC_PERIOD 16

// Cycles between SYSREF pulses, must be a multiple of LMFC_PERIOD
`define SYSREF_PERIOD 64

// Consecutive K28.5 characters needed for code-group sync
`define CGS_COUNT 4

// Per-lane elastic buffer and output sample queue depths
`define LANE_BUF_DEPTH 8
`define SAMPLE_FIFO_DEPTH 8

`endif

// ==== source/rx_link_pkg.sv ====
/* Character codes and sample word types shared by the deframers, the assembler
   and the testbench reference model. */
`include "rx_link_params.svh"

package rx_link_pkg;

  // Control characters as they arrive with the K flag set
  localparam logic [7:0] K28_5   = 8'hBC;
  localparam logic [7:0] K28_3_A = 8'h7C;
  localparam logic [7:0] K28_7_F = 8'hFC;

  // Converter sample, two's complement, two bits narrower than the lane word
  typedef logic [8*`NUM_LANES-3:0] sample_t;

  typedef struct packed {
    sample_t    sample;
    logic [1:0] ctrl;
  } sample_fields_t;

  // The same word seen as lane octets or as sample plus control bits.
  // Octet NUM_LANES-1 carries lane 0, so lane 0 is the top byte
  typedef union packed {
    logic [`NUM_LANES-1:0][7:0] octets;
    sample_fields_t             fields;
  } sample_word_u;

endpackage

// ==== source/link_timing.sv ====
/* SYSREF generation, LMFC tracking, SYNC request and lane buffer release.
   One instance per link, shared by all lane deframers. */
`timescale 1ns/1ps
`include "rx_link_params.svh"

module link_timing (
  input  logic                  core_clk_i,
  input  logic                  rst_n_i,
  input  logic                  link_en_i,
  input  logic                  sysref_en_i,
  input  logic [`NUM_LANES-1:0] cgs_done_i,
  input  logic [`NUM_LANES-1:0] data_ready_i,
  output logic                  sysref_o,
  output logic                  lmfc_edge_o,
  output logic                  sync_n_o,
  output logic                  release_o
);

  localparam int SYSREF_CW = $clog2(`SYSREF_PERIOD);
  localparam int LMFC_CW   = $clog2(`LMFC_PERIOD);

  logic [SYSREF_CW-1:0] sysref_cnt;
  logic [LMFC_CW-1:0]   lmfc_cnt;
  logic                 all_cgs;
  logic                 all_ready;

  // ****************************************
  // SYSREF and LMFC
  // ****************************************

  // The first pulse follows the enable by one cycle, then repeats every period
  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sysref_cnt <= '0;
      sysref_o   <= 1'b0;
    end else if (!sysref_en_i) begin
      sysref_cnt <= '0;
      sysref_o   <= 1'b0;
    end else begin
      sysref_o <= (sysref_cnt == '0);
      if (sysref_cnt == SYSREF_CW'(`SYSREF_PERIOD - 1)) begin
        sysref_cnt <= '0;
      end else begin
        sysref_cnt <= sysref_cnt + 1'b1;
      end
    end
  end

  // A SYSREF pulse restarts the multiframe. Once aligned it coincides with
  // the natural wrap, since the SYSREF period is a whole number of multiframes
  assign lmfc_edge_o = sysref_o | (lmfc_cnt == LMFC_CW'(`LMFC_PERIOD - 1));

  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lmfc_cnt <= '0;
    end else if (lmfc_edge_o) begin
      lmfc_cnt <= '0;
    end else begin
      lmfc_cnt <= lmfc_cnt + 1'b1;
    end
  end

  // ****************************************
  // SYNC request and buffer release
  // ****************************************

  assign all_cgs   = &cgs_done_i;
  assign all_ready = &data_ready_i;

  // Both only change state on a multiframe boundary, which fixes the latency
  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_n_o  <= 1'b0;
      release_o <= 1'b0;
    end else if (!link_en_i) begin
      sync_n_o  <= 1'b0;
      release_o <= 1'b0;
    end else if (lmfc_edge_o) begin
      if (all_cgs) begin
        sync_n_o <= 1'b1;
      end
      if (all_ready) begin
        release_o <= 1'b1;
      end
    end
  end

endmodule

// ==== source/lane_deframer.sv ====
/* Receive deframer for one lane: comma hunt, alignment character replacement
   and an elastic buffer that is drained once the link timing releases it. */
`timescale 1ns/1ps
`include "rx_link_params.svh"

module lane_deframer (
  input  logic       core_clk_i,
  input  logic       rst_n_i,
  input  logic       link_en_i,
  input  logic [7:0] lane_data_i,
  input  logic       lane_charisk_i,
  input  logic       lane_valid_i,
  input  logic       sync_n_i,
  input  logic       release_i,
  output logic       cgs_done_o,
  output logic       data_ready_o,
  output logic [7:0] octet_o,
  output logic       octet_valid_o
);

  import rx_link_pkg::*;

  localparam int AW = $clog2(`LANE_BUF_DEPTH);
  localparam int KW = $clog2(`CGS_COUNT + 1);

  logic [KW-1:0] k_cnt;
  logic          is_comma;
  logic          is_align;
  logic          data_phase;
  logic          wr_en;
  logic          rd_en;
  logic [7:0]    wr_octet;
  logic [7:0]    last_octet;
  logic [AW:0]   wr_ptr;
  logic [AW:0]   rd_ptr;
  logic          buf_empty;
  logic          buf_full;
  logic [7:0]    buf_mem [`LANE_BUF_DEPTH];

  assign is_comma = lane_charisk_i && (lane_data_i == K28_5);
  assign is_align = lane_charisk_i &&
                    ((lane_data_i == K28_3_A) || (lane_data_i == K28_7_F));

  // /A/ and /F/ stand in for a repeat of the previous octet on the wire
  assign wr_octet = is_align ? last_octet : lane_data_i;

  // ****************************************
  // Code-group sync and data start
  // ****************************************

  // Data begins at the first non-comma character once SYNC is deasserted
  assign wr_en = lane_valid_i &&
                 (data_phase || (cgs_done_o && sync_n_i && !is_comma)) &&
                 (!buf_full || rd_en);

  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      k_cnt        <= '0;
      cgs_done_o   <= 1'b0;
      data_phase   <= 1'b0;
      data_ready_o <= 1'b0;
    end else if (!link_en_i) begin
      k_cnt        <= '0;
      cgs_done_o   <= 1'b0;
      data_phase   <= 1'b0;
      data_ready_o <= 1'b0;
    end else begin
      if (lane_valid_i && !cgs_done_o) begin
        if (is_comma) begin
          k_cnt <= k_cnt + 1'b1;
          if (k_cnt == KW'(`CGS_COUNT - 1)) begin
            cgs_done_o <= 1'b1;
          end
        end else begin
          // Any other character breaks the run of commas
          k_cnt <= '0;
        end
      end
      if (wr_en) begin
        data_phase   <= 1'b1;
        data_ready_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      last_octet <= '0;
    end else if (wr_en) begin
      last_octet <= wr_octet;
    end
  end

  // ****************************************
  // Elastic buffer
  // ****************************************

  assign buf_empty = (wr_ptr == rd_ptr);
  assign buf_full  = (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]) && (wr_ptr[AW] != rd_ptr[AW]);

  // Every lane reads on the shared strobe, so all lanes drain in lockstep
  assign rd_en = release_i && lane_valid_i && !buf_empty;

  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      octet_valid_o <= 1'b0;
    end else if (!link_en_i) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      octet_valid_o <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      octet_valid_o <= rd_en;
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (wr_en) begin
      buf_mem[wr_ptr[AW-1:0]] <= wr_octet;
    end
    if (rd_en) begin
      octet_o <= buf_mem[rd_ptr[AW-1:0]];
    end
  end

endmodule

// ==== source/sample_assembler.sv ====
/* Joins the released lane octets into samples, queues them and hands them out
   over a four-phase req/ack handshake. */
`timescale 1ns/1ps
`include "rx_link_params.svh"

module sample_assembler (
  input  logic                       core_clk_i,
  input  logic                       rst_n_i,
  input  logic [`NUM_LANES-1:0][7:0] octet_i,
  input  logic [`NUM_LANES-1:0]      octet_valid_i,
  input  logic                       out_ack_i,
  output rx_link_pkg::sample_t       sample_o,
  output logic [1:0]                 ctrl_o,
  output logic                       out_req_o,
  output logic                       overflow_o,
  output logic                       overrange_o
);

  import rx_link_pkg::*;

  localparam int AW = $clog2(`SAMPLE_FIFO_DEPTH);

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_WAIT_ACK_LOW
  } hs_state_e;

  hs_state_e    state;
  sample_word_u word_in;
  sample_word_u word_q;
  sample_word_u head;
  logic         word_vld_q;
  logic         push;
  logic         pop;
  logic [AW:0]  wr_ptr;
  logic [AW:0]  rd_ptr;
  logic         fifo_empty;
  logic         fifo_full;
  sample_word_u fifo_mem [`SAMPLE_FIFO_DEPTH];

  // Lane 0 lands in the most significant octet
  always_comb begin
    word_in = '0;
    for (int i = 0; i < `NUM_LANES; i++) begin
      word_in.octets[`NUM_LANES-1-i] = octet_i[i];
    end
  end

  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      word_vld_q <= 1'b0;
    end else begin
      word_vld_q <= &octet_valid_i;
    end
  end

  always_ff @(posedge core_clk_i) begin
    word_q <= word_in;
  end

  // ****************************************
  // Sample queue
  // ****************************************

  assign fifo_empty = (wr_ptr == rd_ptr);
  assign fifo_full  = (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]) && (wr_ptr[AW] != rd_ptr[AW]);
  assign head       = fifo_mem[rd_ptr[AW-1:0]];

  // On a full queue the newest sample is lost, older ones keep their order
  assign push = word_vld_q && !fifo_full;
  assign pop  = (state == S_IDLE) && !fifo_empty;

  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      overflow_o  <= 1'b0;
      overrange_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (word_vld_q && fifo_full) begin
        overflow_o <= 1'b1;
      end
      // Control bit 1 flags an over-range conversion
      if (word_vld_q && word_q.fields.ctrl[1]) begin
        overrange_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (push) begin
      fifo_mem[wr_ptr[AW-1:0]] <= word_q;
    end
  end

  // ****************************************
  // Four-phase output handshake
  // ****************************************

  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state     <= S_IDLE;
      out_req_o <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (pop) begin
            state     <= S_REQ;
            out_req_o <= 1'b1;
          end
        end
        S_REQ: begin
          if (out_ack_i) begin
            state     <= S_WAIT_ACK_LOW;
            out_req_o <= 1'b0;
          end
        end
        S_WAIT_ACK_LOW: begin
          // The receiver must drop ack before the next request
          if (!out_ack_i) begin
            state <= S_IDLE;
          end
        end
        default: begin
          state     <= S_IDLE;
          out_req_o <= 1'b0;
        end
      endcase
    end
  end

  // Sample and control stay put for the whole request
  always_ff @(posedge core_clk_i) begin
    if (pop) begin
      sample_o <= head.fields.sample;
      ctrl_o   <= head.fields.ctrl;
    end
  end

endmodule

// ==== source/rx_link_top.sv ====
/* Top level of the two-lane ADC receive link.
   Lanes arrive as octets with K flags and leave as handshaked samples. */
`timescale 1ns/1ps
`include "rx_link_params.svh"

module rx_link_top (
  input  logic                    core_clk_i,
  input  logic                    rst_n_i,
  input  logic [`NUM_LANES*8-1:0] lane_data_i,
  input  logic [`NUM_LANES-1:0]   lane_charisk_i,
  input  logic                    lane_valid_i,
  input  logic                    link_en_i,
  input  logic                    sysref_en_i,
  output logic                    sysref_o,
  output logic                    sync_n_o,
  output rx_link_pkg::sample_t    sample_o,
  output logic [1:0]              ctrl_o,
  output logic                    out_req_o,
  input  logic                    out_ack_i,
  output logic                    overflow_o,
  output logic                    overrange_o
);

  // Internal signals

  logic                       lmfc_edge;
  logic                       buf_release;
  logic [`NUM_LANES-1:0]      cgs_done;
  logic [`NUM_LANES-1:0]      data_ready;
  logic [`NUM_LANES-1:0][7:0] lane_octet;
  logic [`NUM_LANES-1:0]      octet_valid;

  link_timing u_link_timing (
    .core_clk_i   (core_clk_i),
    .rst_n_i      (rst_n_i),
    .link_en_i    (link_en_i),
    .sysref_en_i  (sysref_en_i),
    .cgs_done_i   (cgs_done),
    .data_ready_i (data_ready),
    .sysref_o     (sysref_o),
    .lmfc_edge_o  (lmfc_edge),
    .sync_n_o     (sync_n_o),
    .release_o    (buf_release));

  // One deframer per lane, all sharing SYNC and the release level
  for (genvar i = 0; i < `NUM_LANES; i++) begin : gen_lane
    lane_deframer u_deframer (
      .core_clk_i     (core_clk_i),
      .rst_n_i        (rst_n_i),
      .link_en_i      (link_en_i),
      .lane_data_i    (lane_data_i[8*i +: 8]),
      .lane_charisk_i (lane_charisk_i[i]),
      .lane_valid_i   (lane_valid_i),
      .sync_n_i       (sync_n_o),
      .release_i      (buf_release),
      .cgs_done_o     (cgs_done[i]),
      .data_ready_o   (data_ready[i]),
      .octet_o        (lane_octet[i]),
      .octet_valid_o  (octet_valid[i]));
  end

  sample_assembler u_assembler (
    .core_clk_i    (core_clk_i),
    .rst_n_i       (rst_n_i),
    .octet_i       (lane_octet),
    .octet_valid_i (octet_valid),
    .out_ack_i     (out_ack_i),
    .sample_o      (sample_o),
    .ctrl_o        (ctrl_o),
    .out_req_o     (out_req_o),
    .overflow_o    (overflow_o),
    .overrange_o   (overrange_o));

endmodule

// ==== dv/tb_clk_gen.sv ====
/* Free-running core clock for the receive link testbench, 20 ns period */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o
);

  localparam realtime HALF_PERIOD = 10ns;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(HALF_PERIOD) clk_o = ~clk_o;
    end
  end

endmodule

// ==== dv/rx_link_asserts.sv ====
/* Protocol checks bound onto the receive link top level.
   Covers the output handshake, lane lockstep and SYNC timing */
`timescale 1ns/1ps
`include "rx_link_params.svh"

module rx_link_asserts (
  input logic                  clk_i,
  input logic                  rst_n_i,
  input logic                  req_i,
  input logic                  ack_i,
  input rx_link_pkg::sample_t  sample_i,
  input logic                  sync_n_i,
  input logic                  lmfc_edge_i,
  input logic [`NUM_LANES-1:0] octet_valid_i
);

  // A request only drops once the receiver has acknowledged it
  req_falls_after_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(req_i) |-> $past(ack_i))
    else $error("out_req_o fell without out_ack_i");

  // The sample is held for the whole request
  sample_stable_in_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_i && $past(req_i)) |-> $stable(sample_i))
    else $error("sample_o changed while out_req_o was high");

  // All lanes drain in lockstep
  lanes_in_lockstep: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (octet_valid_i == '0) || (octet_valid_i == '1))
    else $error("lane octet_valid signals differ");

  sync_on_lmfc_edge: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(sync_n_i) |-> $past(lmfc_edge_i))
    else $error("sync_n_o rose without an LMFC edge");

endmodule

// ==== dv/tb_rx_link.sv ====
/* Testbench for the two-lane receive link. Brings the link up, streams lane
   octets and checks the handshaked samples against a reference model */
`timescale 1ns/1ps
`include "rx_link_params.svh"

module tb_rx_link;

  import rx_link_pkg::*;

  localparam int RESET_CYCLES = 5;
  localparam int N_DATA       = 24;
  localparam int PAD          = 10;
  localparam int N_BP         = 40;
  localparam int HUNT_LIMIT   = 40;
  localparam int LANE0_CHARS  = 48;
  localparam int STREAM_MAX   = 56;
  localparam int IDLE_CYCLES  = 20;
  localparam int DRAIN_CYCLES = 400;
  localparam int TOTAL_CHARS  = LANE0_CHARS + 5 * HUNT_LIMIT + 3 * (N_DATA + PAD + 3) +
                                (N_BP + PAD + 3);
  localparam int WATCHDOG_CYCLES = TOTAL_CHARS * 4 + 2000;

  logic                    clk;
  logic                    rst_n_i;
  logic [`NUM_LANES*8-1:0] lane_data_i;
  logic [`NUM_LANES-1:0]   lane_charisk_i;
  logic                    lane_valid_i;
  logic                    link_en_i;
  logic                    sysref_en_i;
  logic                    sysref_o;
  logic                    sync_n_o;
  sample_t                 sample_o;
  logic [1:0]              ctrl_o;
  logic                    out_req_o;
  logic                    out_ack_i;
  logic                    overflow_o;
  logic                    overrange_o;

  logic [31:0]  rng;
  logic [7:0]   lane_stream [`NUM_LANES][STREAM_MAX];
  logic         lane_k [`NUM_LANES][STREAM_MAX];
  int           skew [`NUM_LANES];
  int           stream_len;
  sample_word_u exp_q [$];
  bit           subseq_mode;
  int           ack_min;
  int           ack_max;
  sample_t      got_sample;
  logic [1:0]   got_ctrl;
  event         hs_done;
  string        test_name;
  int           n_out;
  int           errors;
  int           tests_run;
  int           tests_failed;

  tb_clk_gen u_clk (
    .clk_o (clk));

  rx_link_top u_dut (
    .core_clk_i     (clk),
    .rst_n_i        (rst_n_i),
    .lane_data_i    (lane_data_i),
    .lane_charisk_i (lane_charisk_i),
    .lane_valid_i   (lane_valid_i),
    .link_en_i      (link_en_i),
    .sysref_en_i    (sysref_en_i),
    .sysref_o       (sysref_o),
    .sync_n_o       (sync_n_o),
    .sample_o       (sample_o),
    .ctrl_o         (ctrl_o),
    .out_req_o      (out_req_o),
    .out_ack_i      (out_ack_i),
    .overflow_o     (overflow_o),
    .overrange_o    (overrange_o));

  bind rx_link_top rx_link_asserts u_asserts (
    .clk_i         (core_clk_i),
    .rst_n_i       (rst_n_i),
    .req_i         (out_req_o),
    .ack_i         (out_ack_i),
    .sample_i      (sample_o),
    .sync_n_i      (sync_n_o),
    .lmfc_edge_i   (lmfc_edge),
    .octet_valid_i (octet_valid));

  // ****************************************
  // Random numbers and reference model
  // ****************************************

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // Expected word for read index idx where alignment characters repeat the
  // previous data octet of their own lane
  function automatic sample_word_u ref_word(input int idx);
    sample_word_u w;
    logic [7:0]   prev;
    logic [7:0]   oct;
    w = '0;
    for (int i = 0; i < `NUM_LANES; i++) begin
      prev = 8'h00;
      oct  = 8'h00;
      for (int j = 0; j <= idx; j++) begin
        if (lane_k[i][j] && (lane_stream[i][j] == K28_3_A || lane_stream[i][j] == K28_7_F)) begin
          oct = prev;
        end else begin
          oct = lane_stream[i][j];
        end
        prev = oct;
      end
      w.octets[`NUM_LANES-1-i] = oct;
    end
    return w;
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("ERR %s %s expected %0h actual %0h", test_name, what, exp, act);
    errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("test %s failure: %s", test_name, msg);
    errors++;
  endtask

  // ****************************************
  // Receiver side and comparator
  // ****************************************

  initial begin : ack_responder
    int delay;
    forever begin
      @(negedge clk);
      if (out_req_o && !out_ack_i) begin
        got_sample = sample_o;
        got_ctrl   = ctrl_o;
        delay = ack_min + int'(next_rand() % (ack_max - ack_min + 1));
        repeat (delay) @(negedge clk);
        out_ack_i = 1'b1;
        @(negedge clk);
        while (out_req_o) begin
          @(negedge clk);
        end
        -> hs_done;
        out_ack_i = 1'b0;
      end
    end
  end

  always @(hs_done) begin : compare
    sample_word_u exp_w;
    bit           found;
    n_out++;
    if (subseq_mode) begin
      // Dropped samples are skipped, order must still hold
      found = 1'b0;
      while (!found && exp_q.size() > 0) begin
        exp_w = exp_q.pop_front();
        found = (exp_w.fields.sample == got_sample) && (exp_w.fields.ctrl == got_ctrl);
      end
      if (!found) begin
        $display("ERR %s expected a later sent sample actual %0h/%0h", test_name,
                 got_sample, got_ctrl);
        errors++;
      end
    end else if (exp_q.size() == 0) begin
      report_failure("a sample came out with none left to expect");
    end else begin
      exp_w = exp_q.pop_front();
      if (exp_w.fields.sample != got_sample || exp_w.fields.ctrl != got_ctrl) begin
        $display("ERR %s expected %0h/%0h actual %0h/%0h", test_name, exp_w.fields.sample,
                 exp_w.fields.ctrl, got_sample, got_ctrl);
        errors++;
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, test_name);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // ****************************************
  // Stimulus helpers
  // ****************************************

  task automatic apply_reset();
    rst_n_i = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
  endtask

  task automatic strobe_lanes(input logic [`NUM_LANES*8-1:0] data,
                              input logic [`NUM_LANES-1:0] kflags, input int gap);
    @(negedge clk);
    lane_data_i    = data;
    lane_charisk_i = kflags;
    lane_valid_i   = 1'b1;
    for (int g = 1; g < gap; g++) begin
      @(negedge clk);
      lane_valid_i = 1'b0;
    end
  endtask

  task automatic gen_streams(input int len, input bit with_align, input bit with_over,
                             input int max_skew);
    logic [31:0] r;
    stream_len = len;
    for (int i = 0; i < `NUM_LANES; i++) begin
      skew[i] = int'(next_rand() % (max_skew + 1));
      for (int j = 0; j < len + 3; j++) begin
        r = next_rand();
        lane_stream[i][j] = r[7:0];
        lane_k[i][j]      = 1'b0;
        // The last lane holds the control bits of each sample
        if (i == `NUM_LANES - 1) begin
          lane_stream[i][j][1] = with_over && (r[10:9] == 2'b11);
        end
        if (with_align && j > 0 && r[15:13] == 3'd0) begin
          lane_stream[i][j] = r[16] ? K28_3_A : K28_7_F;
          lane_k[i][j]      = 1'b1;
        end
      end
    end
    if (with_over) begin
      lane_stream[`NUM_LANES-1][2] = 8'h42;
      lane_k[`NUM_LANES-1][2]      = 1'b0;
    end
  endtask

  task automatic bring_up(input int gap);
    int n;
    @(negedge clk);
    link_en_i = 1'b1;
    n = 0;
    while (!sync_n_o && n < HUNT_LIMIT) begin
      strobe_lanes({`NUM_LANES{K28_5}}, '1, gap);
      n++;
    end
    if (!sync_n_o) begin
      report_failure("sync_n_o never rose during comma hunt");
    end
  endtask

  task automatic send_stream(input int gap_min, input int gap_max);
    logic [`NUM_LANES*8-1:0] data;
    logic [`NUM_LANES-1:0]   kflags;
    int                      max_skew;
    int                      idx;
    int                      gap;
    max_skew = 0;
    for (int i = 0; i < `NUM_LANES; i++) begin
      if (skew[i] > max_skew) begin
        max_skew = skew[i];
      end
    end
    for (int j = 0; j < stream_len + max_skew; j++) begin
      for (int i = 0; i < `NUM_LANES; i++) begin
        idx = j - skew[i];
        if (idx < 0) begin
          data[8*i +: 8] = K28_5;
          kflags[i]      = 1'b1;
        end else begin
          data[8*i +: 8] = lane_stream[i][idx];
          kflags[i]      = lane_k[i][idx];
        end
      end
      gap = gap_min + int'(next_rand() % (gap_max - gap_min + 1));
      strobe_lanes(data, kflags, gap);
    end
    @(negedge clk);
    lane_valid_i = 1'b0;
  endtask

  // Output is drained once the request line has been quiet for a while
  task automatic wait_idle();
    int quiet;
    quiet = 0;
    while (quiet < IDLE_CYCLES) begin
      @(negedge clk);
      if (out_req_o || out_ack_i) begin
        quiet = 0;
      end else begin
        quiet++;
      end
    end
  endtask

  task automatic run_link_test(input int len, input bit with_align, input bit with_over,
                               input int max_skew, input int gap_min, input int gap_max,
                               input int need);
    int waited;
    gen_streams(len, with_align, with_over, max_skew);
    exp_q.delete();
    for (int k = 0; k < len; k++) begin
      exp_q.push_back(ref_word(k));
    end
    bring_up(gap_min);
    send_stream(gap_min, gap_max);
    waited = 0;
    while (n_out < need && waited < DRAIN_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (n_out < need) begin
      report_mismatch("sample count", need, n_out);
    end
    wait_idle();
    @(negedge clk);
    link_en_i = 1'b0;
    repeat (2) @(negedge clk);
    exp_q.delete();
  endtask

  task automatic start_test(input string name);
    test_name = name;
    n_out     = 0;
  endtask

  task automatic end_test(input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %s: ok, %0d samples out", test_name, n_out);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, errors - err_before);
    end
  endtask

  // ****************************************
  // Tests
  // ****************************************

  task automatic test_sysref_sync();
    int pulse_t [3];
    int pulses;
    int cyc;
    @(negedge clk);
    sysref_en_i = 1'b1;
    pulses = 0;
    cyc    = 0;
    while (pulses < 3 && cyc < 4 * `SYSREF_PERIOD) begin
      @(negedge clk);
      cyc++;
      if (sysref_o) begin
        pulse_t[pulses] = cyc;
        pulses++;
      end
    end
    if (pulses < 3) begin
      report_failure("fewer than three SYSREF pulses seen");
    end else begin
      if (pulse_t[0] != 1) begin
        report_mismatch("first sysref delay", 1, pulse_t[0]);
      end
      for (int k = 1; k < 3; k++) begin
        if (pulse_t[k] - pulse_t[k-1] != `SYSREF_PERIOD) begin
          report_mismatch("sysref spacing", `SYSREF_PERIOD, pulse_t[k] - pulse_t[k-1]);
        end
      end
    end
    // Lane 0 alone cannot complete the sync
    link_en_i = 1'b1;
    for (int k = 0; k < LANE0_CHARS; k++) begin
      strobe_lanes({{(`NUM_LANES-1){8'h00}}, K28_5}, `NUM_LANES'(1), 1);
      if (sync_n_o) begin
        report_mismatch("sync_n with one lane", 0, sync_n_o);
      end
    end
    cyc = 0;
    while (!sync_n_o && cyc <= `CGS_COUNT + 2 * `LMFC_PERIOD) begin
      strobe_lanes({`NUM_LANES{K28_5}}, '1, 1);
      cyc++;
    end
    if (!sync_n_o) begin
      report_failure("sync_n_o did not rise after both lanes sent commas");
    end
    @(negedge clk);
    link_en_i    = 1'b0;
    lane_valid_i = 1'b0;
    @(negedge clk);
    if (sync_n_o) begin
      report_mismatch("sync_n after link disable", 0, sync_n_o);
    end
    @(negedge clk);
  endtask

  initial begin : main
    int err0;
    rng            = 32'h7802;
    rst_n_i        = 1'b0;
    lane_data_i    = '0;
    lane_charisk_i = '0;
    lane_valid_i   = 1'b0;
    link_en_i      = 1'b0;
    sysref_en_i    = 1'b0;
    out_ack_i      = 1'b0;
    subseq_mode    = 1'b0;
    ack_min        = 0;
    ack_max        = 2;
    errors         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    apply_reset();

    start_test("reset_values");
    err0 = errors;
    if (sysref_o) report_mismatch("sysref_o", 0, sysref_o);
    if (sync_n_o) report_mismatch("sync_n_o", 0, sync_n_o);
    if (out_req_o) report_mismatch("out_req_o", 0, out_req_o);
    if (overflow_o) report_mismatch("overflow_o", 0, overflow_o);
    if (overrange_o) report_mismatch("overrange_o", 0, overrange_o);
    end_test(err0);

    start_test("sysref_sync");
    err0 = errors;
    test_sysref_sync();
    end_test(err0);

    start_test("skewed_data");
    err0 = errors;
    run_link_test(N_DATA + PAD, 1'b0, 1'b0, 3, 5, 5, N_DATA);
    if (overrange_o) report_mismatch("overrange_o", 0, overrange_o);
    if (overflow_o) report_mismatch("overflow_o", 0, overflow_o);
    end_test(err0);

    start_test("replace_overrange");
    err0 = errors;
    run_link_test(N_DATA + PAD, 1'b1, 1'b1, 3, 5, 5, N_DATA);
    if (!overrange_o) report_mismatch("overrange_o", 1, overrange_o);
    end_test(err0);

    // Full-rate strobe with a slow receiver fills the sample queue
    start_test("back_pressure");
    err0 = errors;
    ack_min     = 6;
    ack_max     = 6;
    subseq_mode = 1'b1;
    run_link_test(N_BP + PAD, 1'b0, 1'b0, 0, 1, 1, 1);
    subseq_mode = 1'b0;
    if (!overflow_o) report_mismatch("overflow_o", 1, overflow_o);
    if (!overrange_o) report_mismatch("overrange_o held", 1, overrange_o);
    end_test(err0);

    start_test("four_phase");
    err0 = errors;
    apply_reset();
    ack_min = 0;
    ack_max = 5;
    run_link_test(N_DATA + PAD, 1'b0, 1'b0, 2, 4, 5, N_DATA);
    if (overflow_o) report_mismatch("overflow_o", 0, overflow_o);
    end_test(err0);

    $display("summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
             errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+source
source/rx_link_pkg.sv
source/link_timing.sv
source/lane_deframer.sv
source/sample_assembler.sv
source/rx_link_top.sv
dv/tb_clk_gen.sv
dv/rx_link_asserts.sv
dv/tb_rx_link.sv
